// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mpq_engine
FILELIST  ?= mpq_engine.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	@if grep -q 'FAIL: see errors above' $(LOG) || ! grep -q 'PASS: all tests' $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mpq_engine.f ====
rtl/mpq_cfg_pkg.sv
rtl/mpq_types_pkg.sv
rtl/mpq_pkt_store.sv
rtl/mpq_state_update.sv
rtl/mpq_state_table.sv
rtl/mpq_rr_arbiter.sv
rtl/mpq_dispatch.sv
rtl/mpq_engine.sv
sim/mpq_engine_chk.sv
sim/tb_mpq_engine.sv

// ==== rtl/mpq_cfg_pkg.sv ====
package mpq_cfg_pkg;

    // message queues, the message id low bits select one of them
    localparam int unsigned NUM_MPQ = 4;
    localparam int unsigned MPQ_IDX_W = $clog2(NUM_MPQ);

    // static packet slots per queue
    localparam int unsigned PKT_SLOTS_PER_MPQ = 4;
    localparam int unsigned SLOT_IDX_W = $clog2(PKT_SLOTS_PER_MPQ);

    // handler and packet addressing
    localparam int unsigned ADDR_W = 16;
    localparam int unsigned SIZE_W = 8;

    // length and in-flight counters, one spare bit of headroom over a full queue
    localparam int unsigned CNT_W = $clog2(PKT_SLOTS_PER_MPQ + 1) + 1;

    // events seen per cycle: new HER, task sent, feedback
    localparam int unsigned NUM_EVT = 3;

endpackage

// ==== rtl/mpq_dispatch.sv ====
`timescale 1ns/1ns

module mpq_dispatch import mpq_cfg_pkg::*, mpq_types_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 meta_we_i,
    input  logic [MPQ_IDX_W-1:0] meta_widx_i,
    input  mpq_meta_t            meta_i,
    input  logic                 arb_valid_i,
    input  logic [MPQ_IDX_W-1:0] arb_idx_i,
    input  logic                 pop_i,
    input  mpq_state_e           grant_state_i,
    input  mpq_pkt_t             head_i,
    input  logic                 task_ready_i,
    output logic                 grant_o,
    output logic                 task_valid_o,
    output handler_task_t        task_o
);

    typedef enum logic [1:0] {Idle, Ready, Stalled} disp_state_e;

    disp_state_e          state_q;
    disp_state_e          state_d;
    mpq_meta_t            meta_q [NUM_MPQ];
    mpq_meta_t            sel_meta;
    logic [MPQ_IDX_W-1:0] sel_idx_q;
    mpq_state_e           sel_state_q;
    logic                 sel_pop_q;
    handler_task_t        task_q;
    handler_task_t        new_task;

    // metadata is only rewritten while its queue is Free
    always_ff @(posedge clk_i) begin
        if (meta_we_i) begin
            meta_q[meta_widx_i] <= meta_i;
        end
    end

    // a grant while a task is presented pipelines the next read
    always_comb begin
        state_d = state_q;
        grant_o = 1'b0;
        case (state_q)
            Idle: begin
                grant_o = arb_valid_i;
                state_d = arb_valid_i ? Ready : Idle;
            end
            Ready, Stalled: begin
                if (task_ready_i) begin
                    grant_o = arb_valid_i;
                    state_d = arb_valid_i ? Ready : Idle;
                end else begin
                    state_d = Stalled;
                end
            end
            default: state_d = Idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= Idle;
            sel_idx_q   <= '0;
            sel_state_q <= Free;
            sel_pop_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (grant_o) begin
                sel_idx_q   <= arb_idx_i;
                sel_state_q <= grant_state_i;
                sel_pop_q   <= pop_i;
            end
        end
    end

    assign sel_meta = meta_q[sel_idx_q];

    always_comb begin
        new_task.msgid            = sel_idx_q;
        new_task.pkt_addr         = head_i.pkt_addr;
        new_task.pkt_size         = head_i.pkt_size;
        new_task.trigger_feedback = sel_pop_q;
        case (sel_state_q)
            Header:     new_task.handler_addr = sel_meta.hh_addr;
            Payload:    new_task.handler_addr = sel_meta.ph_addr;
            Completion: new_task.handler_addr = sel_meta.th_addr;
            default:    new_task.handler_addr = '0;
        endcase
    end

    // held copy keeps task_o steady through a stall
    always_ff @(posedge clk_i) begin
        task_q <= task_o;
    end

    assign task_valid_o = (state_q != Idle);
    assign task_o       = (state_q == Ready) ? new_task : task_q;

endmodule

// ==== rtl/mpq_engine.sv ====
`timescale 1ns/1ns

module mpq_engine import mpq_cfg_pkg::*, mpq_types_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               her_valid_i,
    input  her_descr_t         her_i,
    output logic               her_ready_o,
    input  logic               task_ready_i,
    output logic               task_valid_o,
    output handler_task_t      task_o,
    input  logic               feedback_valid_i,
    input  feedback_descr_t    feedback_i,
    output logic               feedback_ready_o,
    input  logic               nic_feedback_ready_i,
    output logic               nic_feedback_valid_o,
    output feedback_descr_t    nic_feedback_o,
    output logic [NUM_MPQ-1:0] mpq_full_o
);

    logic [MPQ_IDX_W-1:0] her_idx;
    logic [MPQ_IDX_W-1:0] fb_idx;
    logic                 her_accept;
    logic                 fb_accept;
    mpq_pkt_t             push_pkt;
    mpq_pkt_t             head_pkt;
    logic [NUM_MPQ-1:0]   mpq_ready;
    logic [NUM_MPQ-1:0]   mpq_free;
    logic                 arb_valid;
    logic [MPQ_IDX_W-1:0] arb_idx;
    logic                 arb_grant;
    logic                 pkt_pop;
    mpq_state_e           grant_state;

    assign her_idx           = her_i.msgid[MPQ_IDX_W-1:0];
    assign fb_idx            = feedback_i.msgid[MPQ_IDX_W-1:0];
    assign her_ready_o       = !mpq_full_o[her_idx];
    assign her_accept        = her_valid_i && her_ready_o;
    assign fb_accept         = feedback_valid_i && feedback_ready_o;
    assign push_pkt.pkt_addr = her_i.pkt_addr;
    assign push_pkt.pkt_size = her_i.pkt_size;

    // feedback goes on to the NIC only when the task asked for it
    assign feedback_ready_o     = nic_feedback_ready_i;
    assign nic_feedback_valid_o = feedback_valid_i && feedback_i.trigger_feedback;
    assign nic_feedback_o       = feedback_i;

    mpq_pkt_store u_pkt_store (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .push_i     (her_accept),
        .push_idx_i (her_idx),
        .push_pkt_i (push_pkt),
        .pop_i      (pkt_pop),
        .rd_idx_i   (arb_idx),
        .rd_en_i    (arb_grant),
        .head_o     (head_pkt),
        .full_o     (mpq_full_o)
    );

    mpq_state_table u_state_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .her_push_i    (her_accept),
        .her_idx_i     (her_idx),
        .her_has_hh_i  (her_i.meta.hh_addr != '0),
        .her_has_th_i  (her_i.meta.th_addr != '0),
        .her_eom_i     (her_i.eom),
        .grant_i       (arb_grant),
        .grant_idx_i   (arb_idx),
        .fb_accept_i   (fb_accept),
        .fb_idx_i      (fb_idx),
        .ready_o       (mpq_ready),
        .free_o        (mpq_free),
        .pop_o         (pkt_pop),
        .grant_state_o (grant_state)
    );

    mpq_rr_arbiter u_arbiter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (mpq_ready),
        .grant_i (arb_grant),
        .valid_o (arb_valid),
        .idx_o   (arb_idx)
    );

    // the first HER of a message carries its handler addresses
    mpq_dispatch u_dispatch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .meta_we_i     (her_accept && mpq_free[her_idx]),
        .meta_widx_i   (her_idx),
        .meta_i        (her_i.meta),
        .arb_valid_i   (arb_valid),
        .arb_idx_i     (arb_idx),
        .pop_i         (pkt_pop),
        .grant_state_i (grant_state),
        .head_i        (head_pkt),
        .task_ready_i  (task_ready_i),
        .grant_o       (arb_grant),
        .task_valid_o  (task_valid_o),
        .task_o        (task_o)
    );

endmodule

// ==== rtl/mpq_pkt_store.sv ====
`timescale 1ns/1ns

module mpq_pkt_store import mpq_cfg_pkg::*, mpq_types_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  logic [MPQ_IDX_W-1:0] push_idx_i,
    input  mpq_pkt_t             push_pkt_i,
    input  logic                 pop_i,
    input  logic [MPQ_IDX_W-1:0] rd_idx_i,
    input  logic                 rd_en_i,
    output mpq_pkt_t             head_o,
    output logic [NUM_MPQ-1:0]   full_o
);

    mpq_pkt_t              slots_q  [NUM_MPQ][PKT_SLOTS_PER_MPQ];
    logic [SLOT_IDX_W-1:0] rd_ptr_q [NUM_MPQ];
    logic [SLOT_IDX_W-1:0] wr_ptr_q [NUM_MPQ];
    logic [CNT_W-1:0]      count_q  [NUM_MPQ];

    // slot storage and head register carry no reset
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            slots_q[push_idx_i][wr_ptr_q[push_idx_i]] <= push_pkt_i;
        end
        // head is read before a pop at the same edge takes effect
        if (rd_en_i) begin
            head_o <= slots_q[rd_idx_i][rd_ptr_q[rd_idx_i]];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_MPQ; i++) begin
                rd_ptr_q[i] <= '0;
                wr_ptr_q[i] <= '0;
                count_q[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_MPQ; i++) begin
                logic inc;
                logic dec;
                inc = push_i && (push_idx_i == MPQ_IDX_W'(i));
                dec = pop_i && (rd_idx_i == MPQ_IDX_W'(i));
                if (inc) begin
                    wr_ptr_q[i] <= (wr_ptr_q[i] == SLOT_IDX_W'(PKT_SLOTS_PER_MPQ - 1)) ?
                                   '0 : wr_ptr_q[i] + 1'b1;
                end
                if (dec) begin
                    rd_ptr_q[i] <= (rd_ptr_q[i] == SLOT_IDX_W'(PKT_SLOTS_PER_MPQ - 1)) ?
                                   '0 : rd_ptr_q[i] + 1'b1;
                end
                if (inc && !dec) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end else if (dec && !inc) begin
                    count_q[i] <= count_q[i] - 1'b1;
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_MPQ; i++) begin : gen_full
        assign full_o[i] = (count_q[i] == CNT_W'(PKT_SLOTS_PER_MPQ));
    end

endmodule

// ==== rtl/mpq_rr_arbiter.sv ====
`timescale 1ns/1ns

module mpq_rr_arbiter import mpq_cfg_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [NUM_MPQ-1:0]   req_i,
    input  logic                 grant_i,
    output logic                 valid_o,
    output logic [MPQ_IDX_W-1:0] idx_o
);

    logic [MPQ_IDX_W-1:0] prio_q;

    // first requester at or after the priority pointer
    always_comb begin
        int unsigned cand;
        valid_o = 1'b0;
        idx_o   = prio_q;
        for (int unsigned off = 0; off < NUM_MPQ; off++) begin
            cand = (prio_q + off) % NUM_MPQ;
            if (!valid_o && req_i[cand]) begin
                valid_o = 1'b1;
                idx_o   = MPQ_IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= '0;
        end else if (grant_i && valid_o) begin
            prio_q <= (idx_o == MPQ_IDX_W'(NUM_MPQ - 1)) ? '0 : idx_o + 1'b1;
        end
    end

endmodule

// ==== rtl/mpq_state_table.sv ====
`timescale 1ns/1ns

module mpq_state_table import mpq_cfg_pkg::*, mpq_types_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 her_push_i,
    input  logic [MPQ_IDX_W-1:0] her_idx_i,
    input  logic                 her_has_hh_i,
    input  logic                 her_has_th_i,
    input  logic                 her_eom_i,
    input  logic                 grant_i,
    input  logic [MPQ_IDX_W-1:0] grant_idx_i,
    input  logic                 fb_accept_i,
    input  logic [MPQ_IDX_W-1:0] fb_idx_i,
    output logic [NUM_MPQ-1:0]   ready_o,
    output logic [NUM_MPQ-1:0]   free_o,
    output logic                 pop_o,
    output mpq_state_e           grant_state_o
);

    mpq_ctx_t             ctx_q  [NUM_MPQ];
    // event slots: 0 is the HER queue, 1 the granted queue, 2 the feedback queue
    logic [MPQ_IDX_W-1:0] ev_idx [NUM_EVT];
    mpq_ctx_t             ev_ctx [NUM_EVT];
    logic [NUM_EVT-1:0]   ev_any;
    mpq_ctx_t             grant_cur;
    mpq_ctx_t             grant_nxt;

    assign ev_idx[0] = her_idx_i;
    assign ev_idx[1] = grant_idx_i;
    assign ev_idx[2] = fb_idx_i;

    // each slot sees the other events only when they hit the same queue
    for (genvar k = 0; k < NUM_EVT; k++) begin : gen_upd
        logic her_k;
        logic sent_k;
        logic fb_k;

        assign her_k     = her_push_i && (her_idx_i == ev_idx[k]);
        assign sent_k    = grant_i && (grant_idx_i == ev_idx[k]);
        assign fb_k      = fb_accept_i && (fb_idx_i == ev_idx[k]);
        assign ev_any[k] = her_k || sent_k || fb_k;

        mpq_state_update u_state_update (
            .her_new_i    (her_k),
            .task_sent_i  (sent_k),
            .feedback_i   (fb_k),
            .her_has_hh_i (her_has_hh_i),
            .her_has_th_i (her_has_th_i),
            .her_eom_i    (her_eom_i),
            .ctx_i        (ctx_q[ev_idx[k]]),
            .ctx_o        (ev_ctx[k])
        );
    end

    // slots sharing an index compute the same context, so write order is irrelevant
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_MPQ; i++) begin
                ctx_q[i] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_EVT; k++) begin
                if (ev_any[k]) begin
                    ctx_q[ev_idx[k]] <= ev_ctx[k];
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_MPQ; i++) begin : gen_flags
        assign ready_o[i] = (ctx_q[i].state == Header) || (ctx_q[i].state == Completion) ||
                            (ctx_q[i].state == Payload && ctx_q[i].length != '0);
        assign free_o[i]  = (ctx_q[i].state == Free);
    end

    assign grant_cur     = ctx_q[grant_idx_i];
    assign grant_nxt     = ev_ctx[1];
    assign grant_state_o = grant_cur.state;

    // the eom packet stays queued for the completion handler
    assign pop_o = grant_i && (
        (grant_cur.state == Payload && grant_nxt.state == Payload) ||
        (grant_cur.state == Payload && grant_nxt.state == PayloadDraining &&
         !grant_nxt.has_completion) ||
        (grant_cur.state == Completion));

endmodule

// ==== rtl/mpq_state_update.sv ====
`timescale 1ns/1ns

module mpq_state_update import mpq_cfg_pkg::*, mpq_types_pkg::*; (
    input  logic     her_new_i,
    input  logic     task_sent_i,
    input  logic     feedback_i,
    input  logic     her_has_hh_i,
    input  logic     her_has_th_i,
    input  logic     her_eom_i,
    input  mpq_ctx_t ctx_i,
    output mpq_ctx_t ctx_o
);

    // only payload tasks consume a queued packet
    logic pkt_taken;

    assign pkt_taken = task_sent_i && (ctx_i.state == Payload);

    always_comb begin
        ctx_o = ctx_i;

        case ({her_new_i, pkt_taken})
            2'b10:   ctx_o.length = ctx_i.length + 1'b1;
            2'b01:   ctx_o.length = ctx_i.length - 1'b1;
            default: ctx_o.length = ctx_i.length;
        endcase

        case ({task_sent_i, feedback_i})
            2'b10:   ctx_o.in_flight = ctx_i.in_flight + 1'b1;
            2'b01:   ctx_o.in_flight = ctx_i.in_flight - 1'b1;
            default: ctx_o.in_flight = ctx_i.in_flight;
        endcase

        ctx_o.eom_seen = ctx_i.eom_seen || (her_new_i && her_eom_i);

        case (ctx_i.state)
            Free: begin
                if (her_new_i) begin
                    ctx_o.state          = her_has_hh_i ? Header : Payload;
                    ctx_o.has_completion = her_has_th_i;
                    ctx_o.eom_seen       = her_eom_i;
                end
            end
            Header: begin
                if (task_sent_i) begin
                    ctx_o.state = HeaderRunning;
                end
            end
            HeaderRunning: begin
                if (feedback_i) begin
                    ctx_o.state = Payload;
                end
            end
            Payload: begin
                if (task_sent_i && ctx_i.eom_seen && ctx_i.length == CNT_W'(1)) begin
                    ctx_o.state = PayloadDraining;
                end
            end
            PayloadDraining: begin
                // last outstanding payload task came back
                if (feedback_i && ctx_i.in_flight == CNT_W'(1)) begin
                    if (ctx_i.has_completion) begin
                        ctx_o.state = Completion;
                    end else begin
                        ctx_o.state    = Free;
                        ctx_o.eom_seen = 1'b0;
                    end
                end
            end
            Completion: begin
                if (task_sent_i) begin
                    ctx_o.state = CompletionRunning;
                end
            end
            CompletionRunning: begin
                if (feedback_i) begin
                    ctx_o.state          = Free;
                    ctx_o.eom_seen       = 1'b0;
                    ctx_o.has_completion = 1'b0;
                end
            end
            default: ctx_o.state = Free;
        endcase
    end

endmodule

// ==== rtl/mpq_types_pkg.sv ====
package mpq_types_pkg;

    import mpq_cfg_pkg::*;

    // phase of one message queue, Free must stay at zero
    typedef enum logic [2:0] {
        Free,
        Header,
        HeaderRunning,
        Payload,
        PayloadDraining,
        Completion,
        CompletionRunning
    } mpq_state_e;

    typedef struct packed {
        mpq_state_e       state;
        logic [CNT_W-1:0] length;
        logic [CNT_W-1:0] in_flight;
        logic             eom_seen;
        logic             has_completion;
    } mpq_ctx_t;

    // a zero hh_addr or th_addr means no such handler
    typedef struct packed {
        logic [ADDR_W-1:0] hh_addr;
        logic [ADDR_W-1:0] ph_addr;
        logic [ADDR_W-1:0] th_addr;
    } mpq_meta_t;

    typedef struct packed {
        logic [MPQ_IDX_W-1:0] msgid;
        logic [ADDR_W-1:0]    pkt_addr;
        logic [SIZE_W-1:0]    pkt_size;
        logic                 eom;
        mpq_meta_t            meta;
    } her_descr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] pkt_addr;
        logic [SIZE_W-1:0] pkt_size;
    } mpq_pkt_t;

    typedef struct packed {
        logic [MPQ_IDX_W-1:0] msgid;
        logic [ADDR_W-1:0]    handler_addr;
        logic [ADDR_W-1:0]    pkt_addr;
        logic [SIZE_W-1:0]    pkt_size;
        logic                 trigger_feedback;
    } handler_task_t;

    typedef struct packed {
        logic [MPQ_IDX_W-1:0] msgid;
        logic                 trigger_feedback;
    } feedback_descr_t;

endpackage

// ==== sim/mpq_engine_chk.sv ====
`timescale 1ns/1ns

module mpq_engine_chk import mpq_cfg_pkg::*, mpq_types_pkg::*; (
    input logic          clk_i,
    input logic          rst_ni,
    input logic          task_valid_i,
    input logic          task_ready_i,
    input handler_task_t task_i,
    input mpq_ctx_t      ctx_i [NUM_MPQ]
);

    // a stalled task stays presented and unchanged
    a_task_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        task_valid_i && !task_ready_i |=> task_valid_i && $stable(task_i))
        else $error("task output dropped or changed while stalled");

    // in_flight moves by at most one per cycle, so a wrap is a jump between zero and all ones
    for (genvar i = 0; i < NUM_MPQ; i++) begin : gen_in_flight
        a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
            $past(ctx_i[i].in_flight) == '0 |-> ctx_i[i].in_flight != {CNT_W{1'b1}})
            else $error("in_flight of queue %0d wrapped below zero", i);
        a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
            $past(ctx_i[i].in_flight) == {CNT_W{1'b1}} |-> ctx_i[i].in_flight != '0)
            else $error("in_flight of queue %0d wrapped past its maximum", i);
    end

endmodule

// ==== sim/tb_mpq_engine.sv ====
`timescale 1ns/1ns

module tb_mpq_engine import mpq_cfg_pkg::*, mpq_types_pkg::*; ();

    localparam int unsigned SEED         = 32'h744f6219;
    localparam int unsigned RST_CYCLES   = 16;
    localparam int unsigned MAX_PKTS     = 6;
    localparam int unsigned FB_DELAY_MAX = 6;
    localparam int unsigned SKIP_ROUNDS  = 2;
    localparam int unsigned STALL_ROUNDS = 6;
    localparam int unsigned NUM_ROUNDS   = 2 + SKIP_ROUNDS + STALL_ROUNDS;
    // the fill message plus one message per queue and round
    localparam int unsigned NUM_MSGS     = 1 + NUM_ROUNDS * NUM_MPQ;
    localparam int unsigned CYC_PER_TASK = 4 * (FB_DELAY_MAX + 4);
    localparam int unsigned CYCLE_LIMIT  = RST_CYCLES + 100 +
                                           NUM_MSGS * (MAX_PKTS + 2) * CYC_PER_TASK;

    logic               clk_i;
    logic               rst_ni;
    logic               her_valid_i;
    her_descr_t         her_i;
    logic               her_ready_o;
    logic               task_ready_i;
    logic               task_valid_o;
    handler_task_t      task_o;
    logic               feedback_valid_i;
    feedback_descr_t    feedback_i;
    logic               feedback_ready_o;
    logic               nic_feedback_ready_i;
    logic               nic_feedback_valid_o;
    feedback_descr_t    nic_feedback_o;
    logic [NUM_MPQ-1:0] mpq_full_o;

    her_descr_t           her_q[$];
    her_descr_t           msg_q[NUM_MPQ][$];
    handler_task_t        exp_q[NUM_MPQ][$];
    feedback_descr_t      fb_q[$];
    int unsigned          fb_due_q[$];
    logic [MPQ_IDX_W-1:0] idle_msgid = '0;
    bit                   hold_ready = 1'b0;
    bit                   stall_mode = 1'b0;
    int unsigned          cycle_no = 0;
    int unsigned          wd_cycles = 0;
    int unsigned          checks = 0;
    int unsigned          errors = 0;
    int unsigned          tasks_seen = 0;
    int unsigned          nic_fwd = 0;
    int unsigned          msgs = 0;

    mpq_engine u_mpq_engine (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .her_valid_i          (her_valid_i),
        .her_i                (her_i),
        .her_ready_o          (her_ready_o),
        .task_ready_i         (task_ready_i),
        .task_valid_o         (task_valid_o),
        .task_o               (task_o),
        .feedback_valid_i     (feedback_valid_i),
        .feedback_i           (feedback_i),
        .feedback_ready_o     (feedback_ready_o),
        .nic_feedback_ready_i (nic_feedback_ready_i),
        .nic_feedback_valid_o (nic_feedback_valid_o),
        .nic_feedback_o       (nic_feedback_o),
        .mpq_full_o           (mpq_full_o)
    );

    bind mpq_engine mpq_engine_chk u_engine_chk (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .task_valid_i (task_valid_o),
        .task_ready_i (task_ready_i),
        .task_i       (task_o),
        .ctx_i        (u_state_table.ctx_q)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [ADDR_W-1:0] rand_handler();
        logic [ADDR_W-1:0] a;
        a = ADDR_W'($urandom);
        return (a == '0) ? ADDR_W'(1) : a;
    endfunction

    // queue the HERs of one message and the tasks it must produce
    task automatic add_message(int unsigned q, int unsigned n, bit has_hh, bit has_th);
        mpq_meta_t     meta;
        her_descr_t    her;
        handler_task_t t;
        meta.hh_addr = has_hh ? rand_handler() : '0;
        meta.ph_addr = ADDR_W'($urandom);
        meta.th_addr = has_th ? rand_handler() : '0;
        msgs++;
        for (int unsigned i = 0; i < n; i++) begin
            her.msgid    = MPQ_IDX_W'(q);
            her.pkt_addr = ADDR_W'($urandom);
            her.pkt_size = SIZE_W'($urandom);
            her.eom      = (i == n - 1);
            her.meta     = meta;
            msg_q[q].push_back(her);
            t.msgid    = her.msgid;
            t.pkt_addr = her.pkt_addr;
            t.pkt_size = her.pkt_size;
            // header sees the first packet but leaves it queued
            if (i == 0 && has_hh) begin
                t.handler_addr     = meta.hh_addr;
                t.trigger_feedback = 1'b0;
                exp_q[q].push_back(t);
            end
            t.handler_addr     = meta.ph_addr;
            t.trigger_feedback = !(her.eom && has_th);
            exp_q[q].push_back(t);
            // completion reuses the eom packet and releases it
            if (her.eom && has_th) begin
                t.handler_addr     = meta.th_addr;
                t.trigger_feedback = 1'b1;
                exp_q[q].push_back(t);
            end
        end
    endtask

    // interleave the per-queue HER lists at random
    task automatic merge_hers();
        int unsigned left;
        int unsigned q;
        left = 0;
        for (int i = 0; i < NUM_MPQ; i++) begin
            left += msg_q[i].size();
        end
        while (left > 0) begin
            q = $urandom_range(0, NUM_MPQ - 1);
            if (msg_q[q].size() > 0) begin
                her_q.push_back(msg_q[q].pop_front());
                left--;
            end
        end
    endtask

    task automatic take_task(handler_task_t t);
        handler_task_t   e;
        feedback_descr_t fb;
        tasks_seen++;
        if (exp_q[t.msgid].size() == 0) begin
            errors++;
            $display("ERROR: task for msgid %0d at %0t was not expected", t.msgid, $time);
        end else begin
            e = exp_q[t.msgid].pop_front();
            check_value("task_o", 64'(t), 64'(e));
        end
        // earliest feedback is accepted one edge after the task
        fb.msgid            = t.msgid;
        fb.trigger_feedback = t.trigger_feedback;
        fb_q.push_back(fb);
        fb_due_q.push_back(cycle_no + 1 + $urandom_range(0, FB_DELAY_MAX));
    endtask

    // drive on the falling edge, then act on what the next rising edge accepts
    task automatic run_cycle();
        @(negedge clk_i);
        cycle_no++;
        her_valid_i = (her_q.size() > 0) && (!stall_mode || $urandom_range(0, 3) != 0);
        if (her_q.size() > 0) begin
            her_i = her_q[0];
        end else begin
            her_i       = '0;
            her_i.msgid = idle_msgid;
        end
        task_ready_i         = !hold_ready && (!stall_mode || $urandom_range(0, 9) < 6);
        nic_feedback_ready_i = !stall_mode || $urandom_range(0, 9) < 8;
        if (fb_q.size() > 0 && fb_due_q[0] <= cycle_no) begin
            feedback_valid_i = 1'b1;
            feedback_i       = fb_q[0];
        end else begin
            feedback_valid_i            = 1'b0;
            feedback_i.msgid            = MPQ_IDX_W'($urandom);
            feedback_i.trigger_feedback = 1'($urandom);
        end
        #1;
        check_value("nic_feedback_valid_o", 64'(nic_feedback_valid_o),
                    64'(feedback_valid_i && feedback_i.trigger_feedback));
        check_value("nic_feedback_o", 64'(nic_feedback_o), 64'(feedback_i));
        check_value("feedback_ready_o", 64'(feedback_ready_o), 64'(nic_feedback_ready_i));
        if (her_valid_i && her_ready_o) begin
            void'(her_q.pop_front());
        end
        if (task_valid_o && task_ready_i) begin
            take_task(task_o);
        end
        if (feedback_valid_i && feedback_ready_o) begin
            if (feedback_i.trigger_feedback) begin
                nic_fwd++;
            end
            void'(fb_q.pop_front());
            void'(fb_due_q.pop_front());
        end
    endtask

    task automatic run_until_drained();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            run_cycle();
            busy = (her_q.size() > 0) || (fb_q.size() > 0);
            for (int i = 0; i < NUM_MPQ; i++) begin
                if (exp_q[i].size() > 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    // mode 0 has both handlers, 1 walks the four handler combinations, else random
    task automatic run_round(int unsigned mode);
        bit hh;
        bit th;
        for (int unsigned q = 0; q < NUM_MPQ; q++) begin
            case (mode)
                0: begin
                    hh = 1'b1;
                    th = 1'b1;
                end
                1: begin
                    hh = q[0];
                    th = q[1];
                end
                default: begin
                    hh = 1'($urandom);
                    th = 1'($urandom);
                end
            endcase
            add_message(q, $urandom_range(1, MAX_PKTS), hh, th);
        end
        merge_hers();
        run_until_drained();
    endtask

    task automatic report_test(string name, int unsigned err_before);
        $display("test %-8s done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        int unsigned err0;
        int unsigned fill_q;
        void'($urandom(SEED));
        rst_ni               = 1'b0;
        her_valid_i          = 1'b0;
        her_i                = '0;
        task_ready_i         = 1'b0;
        feedback_valid_i     = 1'b0;
        feedback_i           = '0;
        nic_feedback_ready_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        // one queue fills up while its header task is held back
        err0   = errors;
        fill_q = $urandom_range(0, NUM_MPQ - 1);
        idle_msgid = MPQ_IDX_W'(fill_q);
        check_value("mpq_full_o", 64'(mpq_full_o), 64'(0));
        hold_ready = 1'b1;
        add_message(fill_q, PKT_SLOTS_PER_MPQ, 1'b1, 1'b1);
        merge_hers();
        while (her_q.size() > 0) begin
            run_cycle();
        end
        run_cycle();
        check_value("her_ready_o", 64'(her_ready_o), 64'(0));
        check_value("mpq_full_o", 64'(mpq_full_o), 64'(1) << fill_q);
        hold_ready = 1'b0;
        run_until_drained();
        report_test("fill", err0);

        err0 = errors;
        run_round(0);
        report_test("hdr_cpl", err0);

        err0 = errors;
        for (int r = 0; r < SKIP_ROUNDS; r++) begin
            run_round((r == 0) ? 1 : 2);
        end
        report_test("skip", err0);

        err0 = errors;
        stall_mode = 1'b1;
        for (int r = 0; r < STALL_ROUNDS; r++) begin
            run_round(2);
        end
        stall_mode = 1'b0;
        report_test("stall", err0);

        // nothing left to dispatch, then every queue takes a fresh message
        err0 = errors;
        repeat (10) begin
            run_cycle();
            check_value("task_valid_o", 64'(task_valid_o), 64'(0));
            check_value("mpq_full_o", 64'(mpq_full_o), 64'(0));
        end
        run_round(0);
        report_test("idle", err0);

        $display("checks %0d, errors %0d, tasks %0d, messages %0d, forwarded feedback %0d",
                 checks, errors, tasks_seen, msgs, nic_fwd);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        while (wd_cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            wd_cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
